// ==== hdl/spimem_pkg.sv ====
// ==========================================================
// shared definitions for the SPI pattern memory
//   spi_opcode_t  command byte encodings
//   byte_t/word_t data types
//   memory sizes and SPI frame layout constants
// ==========================================================

package spimem_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;

	// command byte, anything unknown behaves as a read
	typedef enum logic [7:0] {
		op_write = 8'h01,
		op_read  = 8'h02
	} spi_opcode_t;

	// 256 words of 32 bits, seen as 1024 bytes on the narrow port
	localparam int word_addr_bits = 8;
	localparam int byte_addr_bits = 10;
	localparam int lane_bits = byte_addr_bits - word_addr_bits;
	localparam int word_count = 1 << word_addr_bits;

	// frame bit counter saturates, so it must reach past the frame length
	localparam int frame_count_bits = 6;

	// opcode 8 bits, address 16 bits, data 32 bits
	localparam logic [frame_count_bits-1:0] opcode_bits = 6'd8;
	localparam logic [frame_count_bits-1:0] data_phase_start = 6'd24;
	localparam logic [frame_count_bits-1:0] frame_bits = 6'd56;

endpackage

// ==== hdl/mem_bus_if.sv ====
// ==========================================================
// word-wide access path from the SPI port to the memory
//   requester and memory modports
// ==========================================================

`timescale 1ns/1ns

interface mem_bus_if;

	logic [spimem_pkg::word_addr_bits-1:0] word_addr;
	spimem_pkg::word_t wdata;
	// one-cycle strobe
	logic write;
	// word at word_addr, one cycle later
	spimem_pkg::word_t rdata;

	modport requester (
		output word_addr,
		output wdata,
		output write,
		input  rdata
	);

	modport memory (
		input  word_addr,
		input  wdata,
		input  write,
		output rdata
	);

endinterface

// ==== hdl/spi_command_port.sv ====
// ==========================================================
// SPI peripheral, mode 0, MSB first
//   oversamples the pins in the clock50 domain
//   decodes opcode, address and data of a 56-bit frame
//   returns the stored word on MISO during the data phase
//   issues a one-cycle memory write after a full write frame
// ==========================================================

`timescale 1ns/1ns

module spi_command_port (
	input  logic clock50,
	input  logic reset3,
	input  logic spi_sclk,
	input  logic spi_mosi,
	input  logic spi_cs,
	output logic spi_miso,
	mem_bus_if.requester bus
);

	// bit 0 is the first stage, bit 1 the stable one
	logic [1:0] sclk_sync;
	logic [1:0] mosi_sync;
	logic [1:0] cs_sync;
	logic sclk_prev;
	logic cs_prev;

	logic cs_active;
	logic sclk_rise;
	logic sclk_fall;
	logic cs_rise;
	logic mosi_bit;

	logic [spimem_pkg::frame_count_bits-1:0] bit_count;
	logic sample_opcode;
	logic sample_address;
	logic addr_strobe;
	logic load_strobe;

	spimem_pkg::spi_opcode_t opcode;
	spimem_pkg::word_t shift_reg;
	spimem_pkg::word_t miso_shift;

	// SPI bits 31:24 belong to lane 0 of the stored word
	function automatic spimem_pkg::word_t swap_bytes(input spimem_pkg::word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// pin synchronizers and edge history
	always_ff @(posedge clock50) begin
		if (reset3) begin
			sclk_sync <= 2'b00;
			sclk_prev <= 1'b0;
			cs_sync   <= 2'b11;
			cs_prev   <= 1'b1;
		end else begin
			sclk_sync <= {sclk_sync[0], spi_sclk};
			sclk_prev <= sclk_sync[1];
			cs_sync   <= {cs_sync[0], spi_cs};
			cs_prev   <= cs_sync[1];
		end
	end

	always_ff @(posedge clock50) begin
		mosi_sync <= {mosi_sync[0], spi_mosi};
	end

	assign cs_active = ~cs_sync[1];
	assign sclk_rise = cs_active & sclk_sync[1] & ~sclk_prev;
	assign sclk_fall = cs_active & ~sclk_sync[1] & sclk_prev;
	assign cs_rise   = cs_sync[1] & ~cs_prev;
	assign mosi_bit  = mosi_sync[1];

	// last bit of the opcode, last bit of the address
	assign sample_opcode  = sclk_rise && (bit_count == spimem_pkg::opcode_bits - 1'b1);
	assign sample_address = sclk_rise && (bit_count == spimem_pkg::data_phase_start - 1'b1);

	// bits counted in this frame, saturating
	always_ff @(posedge clock50) begin
		if (reset3 || !cs_active) begin
			bit_count <= '0;
		end else if (sclk_rise && bit_count != '1) begin
			bit_count <= bit_count + 1'b1;
		end
	end

	always_ff @(posedge clock50) begin
		if (sclk_rise) begin
			shift_reg <= {shift_reg[30:0], mosi_bit};
		end
	end

	always_ff @(posedge clock50) begin
		if (reset3) begin
			opcode <= spimem_pkg::op_read;
		end else if (sample_opcode) begin
			opcode <= spimem_pkg::spi_opcode_t'({shift_reg[6:0], mosi_bit});
		end
	end

	// only the low address bits reach the memory
	always_ff @(posedge clock50) begin
		if (sample_address) begin
			bus.word_addr <= {shift_reg[spimem_pkg::word_addr_bits-2:0], mosi_bit};
		end
	end

	// rdata is valid two cycles after the address is taken
	always_ff @(posedge clock50) begin
		if (reset3) begin
			addr_strobe <= 1'b0;
			load_strobe <= 1'b0;
		end else begin
			addr_strobe <= sample_address;
			load_strobe <= addr_strobe;
		end
	end

	// MISO shifter, first data bit held across the 24th falling edge
	always_ff @(posedge clock50) begin
		if (reset3 || !cs_active) begin
			miso_shift <= '0;
		end else if (load_strobe) begin
			miso_shift <= swap_bytes(bus.rdata);
		end else if (sclk_fall && bit_count > spimem_pkg::data_phase_start) begin
			miso_shift <= {miso_shift[30:0], 1'b0};
		end
	end

	assign spi_miso = miso_shift[31];

	// write only after a complete frame
	always_ff @(posedge clock50) begin
		if (reset3) begin
			bus.write <= 1'b0;
		end else begin
			bus.write <= cs_rise && (bit_count == spimem_pkg::frame_bits)
				&& (opcode == spimem_pkg::op_write);
		end
	end

	// shift register is frozen while spi_cs is high
	assign bus.wdata = swap_bytes(shift_reg);

endmodule

// ==== hdl/pattern_memory.sv ====
// ==========================================================
// pattern memory, 256 x 32 bits
//   wide read/write port on the memory bus, read before write
//   narrow 8-bit read port for the byte streamer
//   one RAM per byte lane, true dual port
// ==========================================================

`timescale 1ns/1ns

module pattern_memory (
	input  logic clock50,
	mem_bus_if.memory bus,
	input  logic [spimem_pkg::byte_addr_bits-1:0] byte_addr,
	output spimem_pkg::byte_t byte_data
);

	logic [spimem_pkg::word_addr_bits-1:0] narrow_word;
	logic [spimem_pkg::lane_bits-1:0] narrow_lane_sel;
	logic [spimem_pkg::lane_bits-1:0] lane_q;
	spimem_pkg::byte_t narrow_lane [1 << spimem_pkg::lane_bits];

	assign narrow_word = byte_addr[spimem_pkg::byte_addr_bits-1:spimem_pkg::lane_bits];
	assign narrow_lane_sel = byte_addr[spimem_pkg::lane_bits-1:0];

	for (genvar lane = 0; lane < (1 << spimem_pkg::lane_bits); lane++) begin : g_lane
		spimem_pkg::byte_t ram [spimem_pkg::word_count];
		spimem_pkg::byte_t wide_q;
		spimem_pkg::byte_t narrow_q;

		// contents come up as zero
		initial begin
			for (int i = 0; i < spimem_pkg::word_count; i++) begin
				ram[i] = '0;
			end
		end

		// wide port
		always_ff @(posedge clock50) begin
			wide_q <= ram[bus.word_addr];
			if (bus.write) begin
				ram[bus.word_addr] <= bus.wdata[8*lane +: 8];
			end
		end

		// narrow port
		always_ff @(posedge clock50) begin
			narrow_q <= ram[narrow_word];
		end

		assign bus.rdata[8*lane +: 8] = wide_q;
		assign narrow_lane[lane] = narrow_q;
	end

	// lane select follows the registered read
	always_ff @(posedge clock50) begin
		lane_q <= narrow_lane_sel;
	end

	assign byte_data = narrow_lane[lane_q];

endmodule

// ==== hdl/byte_serializer.sv ====
// ==========================================================
// free-running byte streamer
//   walks all 1024 memory bytes in order
//   one bit per cycle, MSB first, no gaps
//   LED copy of the current byte, marker at byte 0
// ==========================================================

`timescale 1ns/1ns

module byte_serializer (
	input  logic clock50,
	input  logic reset3,
	output logic [spimem_pkg::byte_addr_bits-1:0] byte_addr,
	input  spimem_pkg::byte_t byte_data,
	output logic serial_out,
	output spimem_pkg::byte_t leds,
	output logic stream_start
);

	// index of the bit now on serial_out
	logic [2:0] bit_count;
	spimem_pkg::byte_t shift_reg;
	logic request;
	logic load;

	// address moves on bit 5, data arrives in bit 7, shifter loads for bit 0
	assign request = (bit_count == 3'd5);
	assign load    = (bit_count == 3'd7);

	always_ff @(posedge clock50) begin
		if (reset3) begin
			// start just before the first load so address 0 goes out first
			bit_count <= 3'd6;
			byte_addr <= '0;
		end else begin
			bit_count <= bit_count + 1'b1;
			if (request) begin
				byte_addr <= byte_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock50) begin
		if (reset3) begin
			shift_reg    <= '0;
			leds         <= '0;
			stream_start <= 1'b0;
		end else begin
			if (load) begin
				shift_reg <= byte_data;
				leds      <= byte_data;
			end else begin
				shift_reg <= {shift_reg[6:0], 1'b0};
			end
			// byte_addr still names the byte being loaded
			stream_start <= load && (byte_addr == '0);
		end
	end

	assign serial_out = shift_reg[7];

endmodule

// ==== hdl/spimem_top.sv ====
// ==========================================================
// SPI-pollable pattern memory, top level
//   SPI command port, pattern memory, byte streamer
// ==========================================================

`timescale 1ns/1ns

module spimem_top (
	input  logic clock50,
	input  logic reset3,
	input  logic spi_sclk,
	input  logic spi_mosi,
	input  logic spi_cs,
	output logic spi_miso,
	output logic serial_out,
	output spimem_pkg::byte_t leds,
	output logic stream_start
);

	logic [spimem_pkg::byte_addr_bits-1:0] byte_addr;
	spimem_pkg::byte_t byte_data;

	mem_bus_if bus ();

	spi_command_port spi_port (
		.clock50  (clock50),
		.reset3   (reset3),
		.spi_sclk (spi_sclk),
		.spi_mosi (spi_mosi),
		.spi_cs   (spi_cs),
		.spi_miso (spi_miso),
		.bus      (bus.requester)
	);

	pattern_memory memory (
		.clock50   (clock50),
		.bus       (bus.memory),
		.byte_addr (byte_addr),
		.byte_data (byte_data)
	);

	byte_serializer streamer (
		.clock50      (clock50),
		.reset3       (reset3),
		.byte_addr    (byte_addr),
		.byte_data    (byte_data),
		.serial_out   (serial_out),
		.leds         (leds),
		.stream_start (stream_start)
	);

endmodule

// ==== sim/spimem_props.sv ====
// ==========================================================
// concurrent assertions for the SPI pattern memory
//   write strobe width and spi_cs level
//   stream_start only on the first bit of a byte
//   bind statements for the SPI port and the streamer
// ==========================================================

`timescale 1ns/1ns

module spimem_props (
	input logic clock50,
	input logic reset3,
	input logic write,
	input logic spi_cs,
	input logic stream_start,
	input logic first_bit
);

	write_one_cycle: assert property (@(posedge clock50) disable iff (reset3)
		write |=> !write)
		else $error("write strobe lasted more than one cycle");

	// write comes only after the frame has ended
	write_cs_high: assert property (@(posedge clock50) disable iff (reset3)
		write |-> spi_cs)
		else $error("write strobe while spi_cs was low");

	start_on_first_bit: assert property (@(posedge clock50) disable iff (reset3)
		stream_start |-> first_bit)
		else $error("stream_start outside bit 0 of a byte");

endmodule

bind spi_command_port spimem_props spi_checks (
	.clock50      (clock50),
	.reset3       (reset3),
	.write        (bus.write),
	.spi_cs       (spi_cs),
	.stream_start (1'b0),
	.first_bit    (1'b1)
);

bind byte_serializer spimem_props stream_checks (
	.clock50      (clock50),
	.reset3       (reset3),
	.write        (1'b0),
	.spi_cs       (1'b1),
	.stream_start (stream_start),
	.first_bit    (bit_count == 3'd0)
);

// ==== sim/spimem_tb.sv ====
// ==========================================================
// testbench for the SPI pattern memory
//   clock, reset and SPI host task
//   word model and stream reference function
//   stream monitor, compare tasks and report
// ==========================================================

`timescale 1ns/1ns

module spimem_tb;

	localparam int half_period_cycles = 5;
	localparam int test_words = 20;
	localparam int pass_cycles = 8192;
	// about 60 frames of 600 cycles, then stream passes with margin
	localparam int frame_cycles = 600;
	localparam int max_frames = 60;
	localparam int timeout_cycles = max_frames * frame_cycles + 3 * pass_cycles;

	logic clock50;
	logic reset3;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_cs;
	logic spi_miso;
	logic serial_out;
	spimem_pkg::byte_t leds;
	logic stream_start;

	spimem_pkg::word_t model [256];
	int seed;
	int cycle_count;
	int error_count;
	int test_count;
	int failed_tests;
	int test_errors_before;
	string test_name;
	logic stream_request;
	logic stream_done;
	logic period_done;

	spimem_top uut (
		.clock50      (clock50),
		.reset3       (reset3),
		.spi_sclk     (spi_sclk),
		.spi_mosi     (spi_mosi),
		.spi_cs       (spi_cs),
		.spi_miso     (spi_miso),
		.serial_out   (serial_out),
		.leds         (leds),
		.stream_start (stream_start)
	);

	always #5 clock50 = ~clock50;

	always @(posedge clock50) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout, the run was still going after %0d cycles", timeout_cycles);
			$display("Regression failed");
			$finish;
		end
	end

	// expected stream byte, lane 0 holds SPI data bits 31:24
	function automatic spimem_pkg::byte_t stream_byte(input int index);
		spimem_pkg::word_t w;
		logic [1:0] lane;
		w = model[index[9:2]];
		lane = index[1:0];
		case (lane)
			2'd0: return w[31:24];
			2'd1: return w[23:16];
			2'd2: return w[15:8];
			default: return w[7:0];
		endcase
	endfunction

	task automatic check_word(input string name, input spimem_pkg::word_t expected,
		input spimem_pkg::word_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("Fail %s, %s: expected %08h, actual %08h", test_name, name,
				expected, actual);
		end
	endtask

	task automatic check_byte(input string name, input spimem_pkg::byte_t expected,
		input spimem_pkg::byte_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("Fail %s, %s: expected %02h, actual %02h", test_name, name,
				expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			error_count++;
			$display("Fail %s, %s: expected %b, actual %b", test_name, name,
				expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors_before = error_count;
		test_count++;
	endtask

	task automatic end_test();
		int errors;
		errors = error_count - test_errors_before;
		if (errors == 0) begin
			$display("test %s: ok", test_name);
		end else begin
			failed_tests++;
			$display("test %s: %0d mismatches", test_name, errors);
		end
	endtask

	task automatic check_idle_outputs(input string when);
		check_bit({"serial_out ", when}, 1'b0, serial_out);
		check_bit({"stream_start ", when}, 1'b0, stream_start);
		check_bit({"spi_miso ", when}, 1'b0, spi_miso);
		check_byte({"leds ", when}, 8'h00, leds);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clock50);
		#1;
	endtask

	// mode 0, MSB first; fewer than 56 bits cuts the frame short
	task automatic spi_frame(
		input spimem_pkg::byte_t opcode,
		input logic [15:0] addr,
		input spimem_pkg::word_t data,
		input int nbits,
		output spimem_pkg::word_t miso_word
	);
		logic [55:0] frame;
		frame = {opcode, addr, data};
		miso_word = '0;
		spi_cs = 1'b0;
		wait_cycles(half_period_cycles);
		for (int i = 0; i < nbits; i++) begin
			spi_mosi = frame[55 - i];
			wait_cycles(half_period_cycles);
			// host takes MISO at the rising edge
			if (i >= 24) begin
				miso_word = {miso_word[30:0], spi_miso};
			end
			spi_sclk = 1'b1;
			wait_cycles(half_period_cycles);
			spi_sclk = 1'b0;
		end
		wait_cycles(half_period_cycles);
		spi_cs = 1'b1;
		spi_mosi = 1'b0;
		// room for the write strobe
		wait_cycles(2 * half_period_cycles);
	endtask

	// one full pass from a stream_start pulse, sampled at the falling edge
	initial begin : stream_monitor
		spimem_pkg::byte_t shifted;
		shifted = '0;
		wait (stream_request);
		@(negedge clock50);
		while (!stream_start) begin
			@(negedge clock50);
		end
		for (int c = 0; c < pass_cycles; c++) begin
			if (c > 0) begin
				@(negedge clock50);
				check_bit($sformatf("stream_start at cycle %0d", c), 1'b0, stream_start);
			end
			shifted = {shifted[6:0], serial_out};
			check_byte($sformatf("leds at byte %0d", c / 8), stream_byte(c / 8), leds);
			if (c % 8 == 7) begin
				check_byte($sformatf("stream byte %0d", c / 8), stream_byte(c / 8), shifted);
			end
		end
		stream_done = 1'b1;
		// next marker exactly one pass later
		@(negedge clock50);
		check_bit("stream_start after one pass", 1'b1, stream_start);
		period_done = 1'b1;
	end

	initial begin : main_sequence
		spimem_pkg::word_t rnd;
		spimem_pkg::word_t got;
		spimem_pkg::word_t kept;
		logic [15:0] addrs [test_words];
		logic [7:0] a;

		clock50 = 1'b0;
		reset3 = 1'b1;
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		spi_cs = 1'b1;
		seed = 74107;
		cycle_count = 0;
		error_count = 0;
		test_count = 0;
		failed_tests = 0;
		stream_request = 1'b0;
		stream_done = 1'b0;
		period_done = 1'b0;
		model = '{default: '0};

		begin_test("reset state");
		repeat (4) @(posedge clock50);
		@(negedge clock50);
		check_idle_outputs("during reset");
		@(posedge clock50);
		#1 reset3 = 1'b0;
		// first clock edge out of reset
		@(posedge clock50);
		@(negedge clock50);
		check_idle_outputs("after reset");
		end_test();
		wait_cycles(1);

		begin_test("read after write");
		for (int i = 0; i < test_words; i++) begin
			rnd = $random(seed);
			addrs[i] = rnd[15:0];
			rnd = $random(seed);
			spi_frame(spimem_pkg::op_write, addrs[i], rnd, 56, got);
			model[addrs[i][7:0]] = rnd;
		end
		for (int i = 0; i < test_words; i++) begin
			// upper address byte differs from the one written
			spi_frame(spimem_pkg::op_read, {~addrs[i][15:8], addrs[i][7:0]}, 32'h0, 56,
				got);
			check_word($sformatf("read word %02h", addrs[i][7:0]), model[addrs[i][7:0]], got);
		end
		end_test();

		begin_test("write returns old word");
		a = addrs[0][7:0];
		kept = model[a];
		rnd = $random(seed);
		spi_frame(spimem_pkg::op_write, {8'h00, a}, rnd, 56, got);
		check_word("old word during write", kept, got);
		model[a] = rnd;
		spi_frame(spimem_pkg::op_read, {8'h00, a}, 32'h0, 56, got);
		check_word("new word after write", rnd, got);
		end_test();

		begin_test("aborted frame and unknown opcode");
		a = addrs[1][7:0];
		kept = model[a];
		rnd = $random(seed);
		spi_frame(spimem_pkg::op_write, {8'h00, a}, rnd, 40, got);
		spi_frame(8'h55, {8'h00, a}, ~rnd, 56, got);
		check_word("unknown opcode read", kept, got);
		spi_frame(spimem_pkg::op_read, {8'h00, a}, 32'h0, 56, got);
		check_word("word after aborted and unknown frames", kept, got);
		end_test();

		begin_test("stream content");
		stream_request = 1'b1;
		wait (stream_done);
		end_test();

		begin_test("stream period");
		wait (period_done);
		end_test();

		$display("%0d tests run, %0d failed, %0d check errors",
			test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
hdl/spimem_pkg.sv
hdl/mem_bus_if.sv
hdl/spi_command_port.sv
hdl/pattern_memory.sv
hdl/byte_serializer.sv
hdl/spimem_top.sv
sim/spimem_props.sv
sim/spimem_tb.sv

// ==== Makefile ====
# Verilator build and run for the SPI pattern memory testbench

VERILATOR   ?= verilator
TOP         ?= spimem_tb
FILELIST    ?= tb.f
OBJ_DIR     ?= obj_dir
PASS_TEXT   ?= Regression passed
VFLAGS      ?= --timing --assert --timescale 1ns/1ns
BUILD_FLAGS ?= --binary -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
